// ==== design/backend_pkg.sv ====
`default_nettype none

package backend_pkg;

	localparam int DATA_W = 16;
	localparam int PREG_W = 6;
	localparam int IDX_W = 6;

	// top-level defaults
	localparam int QUEUE_DEPTH_DEF = 4;
	localparam int MULT_STAGES_DEF = 3;

	// shifts use op2[3:0]; ldi passes the immediate through op2
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_shl,
		alu_shr,
		alu_ldi
	} alu_mode_t;

	typedef enum logic {
		unit_alu,
		unit_mult
	} unit_t;

	// renamed instruction as it arrives from dispatch
	typedef struct packed {
		logic [IDX_W-1:0]  idx;
		unit_t             unit;
		alu_mode_t         mode;
		logic [PREG_W-1:0] src1;
		logic [PREG_W-1:0] src2;
		logic [PREG_W-1:0] dst;
		logic              imm_vld;
		logic [DATA_W-1:0] imm;
	} inst_t;

	// operands after register read
	typedef struct packed {
		logic              valid;
		logic [IDX_W-1:0]  idx;
		logic [PREG_W-1:0] dst;
		alu_mode_t         mode;
		logic [DATA_W-1:0] op1;
		logic [DATA_W-1:0] op2;
	} lane_op_t;

	// completion, doubles as a register-file write port
	typedef struct packed {
		logic              valid;
		logic [IDX_W-1:0]  idx;
		logic [PREG_W-1:0] dst;
		logic [DATA_W-1:0] data;
	} done_t;

endpackage

`default_nettype wire

// ==== design/dispatch_queue.sv ====
`default_nettype none

module dispatch_queue import backend_pkg::*; #(
	parameter int QUEUE_DEPTH = QUEUE_DEPTH_DEF
) (
	input  logic  clk,
	input  logic  rst,
	input  inst_t inst_in,
	input  logic  inst_valid,
	input  logic  pop,
	output inst_t head,
	output logic  head_valid,
	output logic  credit_return
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	inst_t            mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// wrap for depths that are not a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(QUEUE_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (inst_valid)
			mem[wr_ptr] <= inst_in;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (inst_valid)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({inst_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	assign head = mem[rd_ptr];
	assign head_valid = (count != '0);

	// one credit back per issued entry
	assign credit_return = pop;

endmodule

`default_nettype wire

// ==== design/issue_stage.sv ====
`default_nettype none

module issue_stage import backend_pkg::*; #(
	parameter int NUM_PREGS = 64
) (
	input  logic              clk,
	input  logic              rst,
	input  inst_t             head,
	input  logic              head_valid,
	input  logic [DATA_W-1:0] rd_data1,
	input  logic [DATA_W-1:0] rd_data2,
	input  done_t             alu_done,
	input  done_t             mult_done,
	output logic              pop,
	output logic [PREG_W-1:0] rd_addr1,
	output logic [PREG_W-1:0] rd_addr2,
	output lane_op_t          alu_op,
	output lane_op_t          mult_op
);

	logic [NUM_PREGS-1:0] busy;
	logic [NUM_PREGS-1:0] set_mask;
	logic [NUM_PREGS-1:0] clr_mask;
	logic                 hazard;
	logic [DATA_W-1:0]    op2;

	// dst is checked too, which blocks WAW while a write is pending
	assign hazard = busy[head.src1] | busy[head.src2] | busy[head.dst];
	assign pop = head_valid & ~hazard;

	assign rd_addr1 = head.src1;
	assign rd_addr2 = head.src2;
	assign op2 = head.imm_vld ? head.imm : rd_data2;

	always_comb begin
		alu_op.valid = pop & (head.unit == unit_alu);
		alu_op.idx = head.idx;
		alu_op.dst = head.dst;
		alu_op.mode = head.mode;
		alu_op.op1 = rd_data1;
		alu_op.op2 = op2;

		mult_op = alu_op;
		mult_op.valid = pop & (head.unit == unit_mult);
	end

	always_comb begin
		set_mask = '0;
		clr_mask = '0;
		if (pop)
			set_mask[head.dst] = 1'b1;
		if (alu_done.valid)
			clr_mask[alu_done.dst] = 1'b1;
		if (mult_done.valid)
			clr_mask[mult_done.dst] = 1'b1;
	end

	// a new claim wins over a release of the same register
	always_ff @(posedge clk) begin
		if (rst)
			busy <= '0;
		else
			busy <= (busy & ~clr_mask) | set_mask;
	end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`default_nettype none

module reg_file import backend_pkg::*; #(
	parameter int NUM_PREGS = 64
) (
	input  logic              clk,
	input  logic              rst,
	input  logic [PREG_W-1:0] rd_addr1,
	input  logic [PREG_W-1:0] rd_addr2,
	input  done_t             alu_done,
	input  done_t             mult_done,
	output logic [DATA_W-1:0] rd_data1,
	output logic [DATA_W-1:0] rd_data2
);

	logic [DATA_W-1:0] regs [NUM_PREGS];

	// ports never collide, scoreboard keeps one writer per register
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_PREGS; i++)
				regs[i] <= '0;
		end else begin
			if (alu_done.valid)
				regs[alu_done.dst] <= alu_done.data;
			if (mult_done.valid)
				regs[mult_done.dst] <= mult_done.data;
		end
	end

	// async reads, written data visible the cycle after done
	assign rd_data1 = regs[rd_addr1];
	assign rd_data2 = regs[rd_addr2];

endmodule

`default_nettype wire

// ==== design/alu_lane.sv ====
`default_nettype none

module alu_lane import backend_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  lane_op_t alu_op,
	output done_t    alu_done
);

	logic [DATA_W-1:0] result;
	logic [3:0]        shamt;

	assign shamt = alu_op.op2[3:0];

	always_comb begin
		case (alu_op.mode)
			alu_add: result = alu_op.op1 + alu_op.op2;
			alu_sub: result = alu_op.op1 - alu_op.op2;
			alu_and: result = alu_op.op1 & alu_op.op2;
			alu_or:  result = alu_op.op1 | alu_op.op2;
			alu_xor: result = alu_op.op1 ^ alu_op.op2;
			alu_shl: result = alu_op.op1 << shamt;
			alu_shr: result = alu_op.op1 >> shamt;
			// op2 already holds the immediate
			alu_ldi: result = alu_op.op2;
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			alu_done.valid <= 1'b0;
		else
			alu_done.valid <= alu_op.valid;
		alu_done.idx <= alu_op.idx;
		alu_done.dst <= alu_op.dst;
		alu_done.data <= result;
	end

endmodule

`default_nettype wire

// ==== design/mult_lane.sv ====
`default_nettype none

module mult_lane import backend_pkg::*; #(
	parameter int MULT_STAGES = MULT_STAGES_DEF
) (
	input  logic     clk,
	input  logic     rst,
	input  lane_op_t mult_op,
	output done_t    mult_done
);

	logic [DATA_W-1:0] product;
	done_t             pipe [MULT_STAGES];

	// low half of the product only
	assign product = mult_op.op1 * mult_op.op2;

	// new op every cycle, tag rides along with the data
	always_ff @(posedge clk) begin
		pipe[0] <= '{
			valid: mult_op.valid,
			idx: mult_op.idx,
			dst: mult_op.dst,
			data: product
		};
		for (int s = 1; s < MULT_STAGES; s++)
			pipe[s] <= pipe[s-1];

		// valids only, payload left as is
		if (rst) begin
			for (int s = 0; s < MULT_STAGES; s++)
				pipe[s].valid <= 1'b0;
		end
	end

	assign mult_done = pipe[MULT_STAGES-1];

endmodule

`default_nettype wire

// ==== design/backend_top.sv ====
`default_nettype none

module backend_top import backend_pkg::*; #(
	parameter int QUEUE_DEPTH = QUEUE_DEPTH_DEF,
	parameter int MULT_STAGES = MULT_STAGES_DEF,
	parameter int NUM_PREGS = 64
) (
	input  logic  clk,
	input  logic  rst,
	input  inst_t inst_in,
	input  logic  inst_valid,
	output logic  credit_return,
	output done_t alu_done,
	output done_t mult_done
);

	inst_t             head;
	logic              head_valid;
	logic              pop;
	logic [PREG_W-1:0] rd_addr1;
	logic [PREG_W-1:0] rd_addr2;
	logic [DATA_W-1:0] rd_data1;
	logic [DATA_W-1:0] rd_data2;
	lane_op_t          alu_op;
	lane_op_t          mult_op;

	dispatch_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) i_queue (
		.clk(clk),
		.rst(rst),
		.inst_in(inst_in),
		.inst_valid(inst_valid),
		.pop(pop),
		.head(head),
		.head_valid(head_valid),
		.credit_return(credit_return)
	);

	issue_stage #(
		.NUM_PREGS(NUM_PREGS)
	) i_issue (
		.clk(clk),
		.rst(rst),
		.head(head),
		.head_valid(head_valid),
		.rd_data1(rd_data1),
		.rd_data2(rd_data2),
		.alu_done(alu_done),
		.mult_done(mult_done),
		.pop(pop),
		.rd_addr1(rd_addr1),
		.rd_addr2(rd_addr2),
		.alu_op(alu_op),
		.mult_op(mult_op)
	);

	// completions double as the write ports
	reg_file #(
		.NUM_PREGS(NUM_PREGS)
	) i_rf (
		.clk(clk),
		.rst(rst),
		.rd_addr1(rd_addr1),
		.rd_addr2(rd_addr2),
		.alu_done(alu_done),
		.mult_done(mult_done),
		.rd_data1(rd_data1),
		.rd_data2(rd_data2)
	);

	alu_lane i_alu (
		.clk(clk),
		.rst(rst),
		.alu_op(alu_op),
		.alu_done(alu_done)
	);

	mult_lane #(
		.MULT_STAGES(MULT_STAGES)
	) i_mult (
		.clk(clk),
		.rst(rst),
		.mult_op(mult_op),
		.mult_done(mult_done)
	);

endmodule

`default_nettype wire

// ==== tests/backend_checker.sv ====
`default_nettype none

module backend_checker import backend_pkg::*; (
	input  logic              clk,
	input  logic              clear,
	input  logic              exp_valid,
	input  logic [IDX_W-1:0]  exp_idx,
	input  logic [PREG_W-1:0] exp_dst,
	input  logic [DATA_W-1:0] exp_data,
	input  done_t             alu_done,
	input  done_t             mult_done,
	output int                seen_count,
	output int                err_count
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [PREG_W-1:0]    want_dst [1 << IDX_W];
	logic [DATA_W-1:0]    want_data [1 << IDX_W];
	logic [(1<<IDX_W)-1:0] expected = '0;
	logic [(1<<IDX_W)-1:0] seen = '0;
	int                   seen_n = 0;
	int                   errs = 0;
	int                   new_seen;
	int                   new_errs;

	assign seen_count = seen_n;
	assign err_count = errs;

	task automatic check_done(input done_t d, input string lane);
		if (!expected[d.idx]) begin
			$display("%s lane completed idx %0d, which was never sent", lane, d.idx);
			new_errs++;
		end else if (seen[d.idx]) begin
			$display("idx %0d completed more than once", d.idx);
			new_errs++;
		end else begin
			seen[d.idx] = 1'b1;
			new_seen++;
			if (d.dst !== want_dst[d.idx] || d.data !== want_data[d.idx]) begin
				$display("FAILED %0t: %s idx %0d gave dst %0d data %h, expected dst %0d data %h",
					$time, lane, d.idx, d.dst, d.data, want_dst[d.idx], want_data[d.idx]);
				new_errs++;
			end
		end
	endtask

	// expectations arrive with the dispatch beat, long before the completion
	always @(posedge clk) begin
		new_seen = 0;
		new_errs = 0;
		if (clear) begin
			expected = '0;
			seen = '0;
			seen_n <= 0;
		end else begin
			if (exp_valid) begin
				expected[exp_idx] = 1'b1;
				want_dst[exp_idx] = exp_dst;
				want_data[exp_idx] = exp_data;
			end
			if (alu_done.valid)
				check_done(alu_done, "alu");
			if (mult_done.valid)
				check_done(mult_done, "mult");
			seen_n <= seen_n + new_seen;
		end
		errs <= errs + new_errs;
	end

endmodule

`default_nettype wire

// ==== tests/backend_chk.sv ====
`default_nettype none

module backend_chk import backend_pkg::*; #(
	parameter int QUEUE_DEPTH = QUEUE_DEPTH_DEF
) (
	input logic  clk,
	input logic  rst,
	input logic  inst_valid,
	input logic  credit_return,
	input done_t alu_done,
	input done_t mult_done
);
	timeunit 1ns;
	timeprecision 1ps;

	// beats taken in but not yet handed back as credits
	int outstanding;

	always @(posedge clk) begin
		if (rst)
			outstanding <= 0;
		else
			outstanding <= outstanding + int'(inst_valid) - int'(credit_return);
	end

	queue_bound: assert property (@(posedge clk) disable iff (rst)
		outstanding <= QUEUE_DEPTH)
		else $error("more beats in flight than queue entries");

	credit_needs_entry: assert property (@(posedge clk) disable iff (rst)
		credit_return |-> (outstanding > 0))
		else $error("credit returned while the queue was empty");

	single_writer: assert property (@(posedge clk) disable iff (rst)
		(alu_done.valid && mult_done.valid) |-> (alu_done.dst != mult_done.dst))
		else $error("both lanes wrote the same register");

	quiet_after_reset: assert property (@(posedge clk)
		$fell(rst) |-> (!alu_done.valid && !mult_done.valid))
		else $error("completion valid right after reset");

endmodule

bind backend_top backend_chk #(
	.QUEUE_DEPTH(QUEUE_DEPTH)
) i_chk (
	.clk(clk),
	.rst(rst),
	.inst_valid(inst_valid),
	.credit_return(credit_return),
	.alu_done(alu_done),
	.mult_done(mult_done)
);

`default_nettype wire

// ==== tests/backend_tb.sv ====
`default_nettype none

module backend_tb import backend_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int QUEUE_DEPTH = QUEUE_DEPTH_DEF;
	localparam int MULT_STAGES = MULT_STAGES_DEF;
	localparam int NUM_PREGS = 64;
	localparam int CREDIT_TIMEOUT = 200;
	localparam int DONE_TIMEOUT = 500;

	logic              clk = 1'b0;
	logic              rst;
	inst_t             inst_in;
	logic              inst_valid;
	logic              credit_return;
	done_t             alu_done;
	done_t             mult_done;
	logic              clear;
	logic              exp_valid;
	logic [IDX_W-1:0]  exp_idx;
	logic [PREG_W-1:0] exp_dst;
	logic [DATA_W-1:0] exp_data;
	int                seen_count;
	int                chk_errs;

	logic [31:0]       rng_state = 32'he1b2;
	logic [DATA_W-1:0] model_regs [NUM_PREGS];
	int                credits;
	int                credit_errs = 0;
	int                tb_errs = 0;
	int                run_len;
	int                max_run;
	int                tests_run = 0;
	int                tests_bad = 0;
	int                completions = 0;
	bit                aborted = 1'b0;

	always #5 clk = ~clk;

	backend_top #(
		.QUEUE_DEPTH(QUEUE_DEPTH),
		.MULT_STAGES(MULT_STAGES),
		.NUM_PREGS(NUM_PREGS)
	) i_dut (
		.clk(clk),
		.rst(rst),
		.inst_in(inst_in),
		.inst_valid(inst_valid),
		.credit_return(credit_return),
		.alu_done(alu_done),
		.mult_done(mult_done)
	);

	backend_checker i_checker (
		.clk(clk),
		.clear(clear),
		.exp_valid(exp_valid),
		.exp_idx(exp_idx),
		.exp_dst(exp_dst),
		.exp_data(exp_data),
		.alu_done(alu_done),
		.mult_done(mult_done),
		.seen_count(seen_count),
		.err_count(chk_errs)
	);

	// sender side credit count, one per beat out, one per credit_return in
	always @(posedge clk) begin
		if (rst) begin
			credits <= QUEUE_DEPTH;
		end else begin
			if (inst_valid && credits <= 0) begin
				$display("credit count went below zero at %0t", $time);
				credit_errs <= credit_errs + 1;
			end else if (credits > QUEUE_DEPTH) begin
				$display("credit count rose above the queue depth at %0t", $time);
				credit_errs <= credit_errs + 1;
			end
			credits <= credits - int'(inst_valid) + int'(credit_return);
		end
	end

	// longest run of back-to-back multiply completions
	always @(posedge clk) begin
		if (clear) begin
			run_len <= 0;
			max_run <= 0;
		end else if (mult_done.valid) begin
			run_len <= run_len + 1;
			if (run_len + 1 > max_run)
				max_run <= run_len + 1;
		end else begin
			run_len <= 0;
		end
	end

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	// sequential execution, one instruction at a time in program order
	function automatic logic [DATA_W-1:0] model_exec(input inst_t inst);
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		a = model_regs[inst.src1];
		b = inst.imm_vld ? inst.imm : model_regs[inst.src2];
		if (inst.unit == unit_mult)
			return a * b;
		case (inst.mode)
			alu_add: return a + b;
			alu_sub: return a - b;
			alu_and: return a & b;
			alu_or:  return a | b;
			alu_xor: return a ^ b;
			alu_shl: return a << b[3:0];
			alu_shr: return a >> b[3:0];
			default: return inst.imm;
		endcase
	endfunction

	// kind 0 ldi fill, 1 all alu modes, 2 independent multiplies,
	// 3 mixed chain on r32-r35, 4 anything on any register
	function automatic inst_t gen_inst(input int kind, input int i);
		inst_t       inst;
		logic [31:0] r;
		r = next_random();
		inst.idx = IDX_W'(i);
		inst.unit = unit_t'(r[18]);
		inst.mode = alu_mode_t'(r[21:19]);
		inst.src1 = r[5:0];
		inst.src2 = r[11:6];
		inst.dst = r[17:12];
		inst.imm_vld = (r[23:22] == 2'b00);
		r = next_random();
		inst.imm = r[15:0];
		if (kind == 1 || kind == 2) begin
			inst.src1 = inst.src1 & 6'h0f;
			inst.src2 = inst.src2 & 6'h0f;
			inst.dst = inst.dst & 6'h0f;
		end
		if (kind == 3) begin
			inst.src1 = 6'h20 | (inst.src1 & 6'h03);
			inst.src2 = 6'h20 | (inst.src2 & 6'h03);
			inst.dst = 6'h20 | (inst.dst & 6'h03);
		end
		case (kind)
			0: begin
				inst.unit = unit_alu;
				inst.mode = alu_ldi;
				inst.dst = PREG_W'(i);
			end
			1: begin
				inst.unit = unit_alu;
				inst.mode = alu_mode_t'(3'(i));
			end
			2: begin
				inst.unit = unit_mult;
				inst.dst = PREG_W'(16 + i);
			end
			3: if (i < 4) begin
				inst.unit = unit_alu;
				inst.mode = alu_ldi;
				inst.dst = PREG_W'(32 + i);
			end
			default: ;
		endcase
		if (inst.mode == alu_ldi)
			inst.imm_vld = 1'b1;
		return inst;
	endfunction

	function automatic int total_errors();
		return chk_errs + credit_errs + tb_errs;
	endfunction

	task automatic send_inst(input inst_t inst, input bit pause);
		logic [DATA_W-1:0] data;
		int                waited;
		waited = 0;
		if (pause && next_random() % 4 == 0) begin
			inst_valid <= 1'b0;
			exp_valid <= 1'b0;
			@(posedge clk);
		end
		// count as it stands after this edge
		while (credits - int'(inst_valid) + int'(credit_return) <= 0
				&& waited < CREDIT_TIMEOUT) begin
			inst_valid <= 1'b0;
			exp_valid <= 1'b0;
			@(posedge clk);
			waited++;
		end
		if (credits - int'(inst_valid) + int'(credit_return) <= 0) begin
			$display("timeout: no credit came back for idx %0d", inst.idx);
			aborted = 1'b1;
		end else begin
			data = model_exec(inst);
			model_regs[inst.dst] = data;
			inst_in <= inst;
			inst_valid <= 1'b1;
			exp_valid <= 1'b1;
			exp_idx <= inst.idx;
			exp_dst <= inst.dst;
			exp_data <= data;
			@(posedge clk);
		end
	endtask

	task automatic run_test(input string name, input int kind, input int n, input bit pause);
		int errs_before;
		int cyc;
		if (aborted)
			return;
		errs_before = total_errors();
		clear <= 1'b1;
		@(posedge clk);
		clear <= 1'b0;
		for (int i = 0; i < n && !aborted; i++)
			send_inst(gen_inst(kind, i), pause);
		inst_valid <= 1'b0;
		exp_valid <= 1'b0;
		cyc = 0;
		while (!aborted && seen_count < n && cyc < DONE_TIMEOUT) begin
			@(posedge clk);
			cyc++;
		end
		if (!aborted && seen_count < n) begin
			$display("timeout: test %s got %0d of %0d completions", name, seen_count, n);
			aborted = 1'b1;
		end
		// drain so a late duplicate still shows up
		repeat (MULT_STAGES + 2) @(posedge clk);
		completions += seen_count;
		if (!aborted && credits != QUEUE_DEPTH) begin
			$display("FAILED %0t: %0d credits after test %s, expected %0d",
				$time, credits, name, QUEUE_DEPTH);
			tb_errs++;
		end
		if (kind == 2 && max_run < MULT_STAGES) begin
			$display("FAILED %0t: longest multiply burst %0d cycles, expected at least %0d",
				$time, max_run, MULT_STAGES);
			tb_errs++;
		end
		tests_run++;
		if (aborted || total_errors() != errs_before)
			tests_bad++;
		$display("test %0d %s: %s", tests_run, name,
			(aborted || total_errors() != errs_before) ? "errors" : "ok");
	endtask

	task automatic finish_run();
		$display("%0d tests, %0d with errors, %0d completions checked, %0d errors",
			tests_run, tests_bad, completions, total_errors());
		if (!aborted && total_errors() == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	endtask

	initial begin
		rst = 1'b1;
		inst_in = '0;
		inst_valid = 1'b0;
		clear = 1'b0;
		exp_valid = 1'b0;
		exp_idx = '0;
		exp_dst = '0;
		exp_data = '0;
		for (int r = 0; r < NUM_PREGS; r++)
			model_regs[r] = '0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		run_test("ldi", 0, 16, 1'b1);
		run_test("alu modes", 1, 48, 1'b1);
		run_test("mult stream", 2, 16, 1'b0);
		run_test("raw waw chain", 3, 40, 1'b1);
		run_test("credits mixed", 4, 60, 1'b1);
		finish_run();
	end

endmodule

`default_nettype wire

// ==== files.f ====
design/backend_pkg.sv
design/dispatch_queue.sv
design/issue_stage.sv
design/reg_file.sv
design/alu_lane.sv
design/mult_lane.sv
design/backend_top.sv
tests/backend_checker.sv
tests/backend_chk.sv
tests/backend_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module backend_tb -f files.f -o backend_sim

output="$(./obj_dir/backend_sim || true)"
echo "$output"

if grep -qx "Result: PASSED" <<< "$output"; then
	exit 0
fi
exit 1
